//--- common/machine_mode_pkg.sv
/*
 * Shared types and constants for the machine-mode privilege unit.
 * Imported by the CSR file, the trap controller and their interfaces.
 */
package machine_mode_pkg;

  // Basic word and CSR address types
  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;

  // Implemented and zero-read CSR addresses
  localparam csr_addr_t MCPUID_ADDR    = 12'hF00;
  localparam csr_addr_t MIMPID_ADDR    = 12'hF01;
  localparam csr_addr_t MHARTID_ADDR   = 12'hF10;
  localparam csr_addr_t MSTATUS_ADDR   = 12'h300;
  localparam csr_addr_t MTVEC_ADDR_CSR = 12'h301;
  localparam csr_addr_t MTDELEG_ADDR   = 12'h302;
  localparam csr_addr_t MIE_ADDR       = 12'h304;
  localparam csr_addr_t MSCRATCH_ADDR  = 12'h340;
  localparam csr_addr_t MEPC_ADDR      = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR    = 12'h342;
  localparam csr_addr_t MBADADDR_ADDR  = 12'h343;
  localparam csr_addr_t MIP_ADDR       = 12'h344;
  localparam csr_addr_t MTOHOST_ADDR   = 12'h780;
  localparam csr_addr_t MFROMHOST_ADDR = 12'h781;

  // Machine privilege level encoding
  localparam logic [1:0] PRV_M = 2'b11;

  // RV32 base in the top bits of mcpuid and the I extension at bit 8
  localparam logic [1:0] BASE_RV32 = 2'b01;
  localparam word_t EXT_I = 32'h0000_0100;
  localparam word_t MCPUID_VALUE = {BASE_RV32, EXT_I[29:0]};

  // Only the first privilege stack level of mstatus is kept
  typedef struct packed {
    logic [25:0] zero;
    logic [1:0]  prv1;
    logic        ie1;
    logic [1:0]  prv;
    logic        ie;
  } mstatus_t;

  // Shared by mie and mip
  typedef struct packed {
    logic [23:0] zero_1;
    logic        mtie;
    logic [2:0]  zero_0;
    logic        msie;
    logic [2:0]  zero_lo;
  } mirq_t;

  // Cause codes; exception and interrupt codes overlap
  typedef logic [30:0] ex_code_t;

  localparam ex_code_t EX_MAL_FETCH    = 31'd0;
  localparam ex_code_t EX_FAULT_FETCH  = 31'd1;
  localparam ex_code_t EX_ILLEGAL_INSN = 31'd2;
  localparam ex_code_t EX_BREAKPOINT   = 31'd3;
  localparam ex_code_t EX_MAL_LOAD     = 31'd4;
  localparam ex_code_t EX_FAULT_LOAD   = 31'd5;
  localparam ex_code_t EX_MAL_STORE    = 31'd6;
  localparam ex_code_t EX_FAULT_STORE  = 31'd7;
  localparam ex_code_t EX_ECALL_M      = 31'd11;
  localparam ex_code_t IRQ_SOFT        = 31'd3;
  localparam ex_code_t IRQ_TIMER       = 31'd7;

  typedef struct packed {
    logic     interrupt;
    ex_code_t code;
  } mcause_t;

  // Read-update word as seen by each target register
  typedef union packed {
    word_t    raw;
    mstatus_t mstatus;
    mirq_t    mirq;
  } csr_word_u;

endpackage

//--- common/prv_pipeline_if.sv
/*
 * Pipeline-side bundle of the privilege unit.
 * The top level drives requests; the CSR file and trap controller answer.
 */
interface prv_pipeline_if import machine_mode_pkg::*; ();

  // CSR access
  csr_addr_t addr;
  logic      swap, set, clr;
  word_t     wdata;
  word_t     rdata;
  logic      invalid_csr;

  // Trap inputs from the pipeline
  word_t ex_pc, ex_badaddr;
  logic  mal_insn, fault_insn, illegal_insn, ebreak, ecall;
  logic  mal_l, fault_l, mal_s, fault_s;
  logic  mret;

  // Redirect
  logic  insert_pc;
  word_t priv_pc;

  modport csr (
    input  addr, swap, set, clr, wdata,
    output rdata, invalid_csr
  );

  modport prv (
    input  swap, set, clr, invalid_csr, ex_pc, ex_badaddr,
    input  mal_insn, fault_insn, illegal_insn, ebreak, ecall,
    input  mal_l, fault_l, mal_s, fault_s, mret,
    output insert_pc, priv_pc
  );

  modport top (
    output addr, swap, set, clr, wdata, ex_pc, ex_badaddr,
    output mal_insn, fault_insn, illegal_insn, ebreak, ecall,
    output mal_l, fault_l, mal_s, fault_s, mret,
    input  rdata, invalid_csr, insert_pc, priv_pc
  );

endinterface

//--- common/csr_prv_if.sv
/*
 * Link between the CSR file and the trap controller.
 * CSR state flows out; trap-time update requests flow back in.
 */
interface csr_prv_if import machine_mode_pkg::*; ();

  // Current register state
  word_t    mtvec, mepc;
  mstatus_t mstatus;
  mirq_t    mie, mip;

  // Update requests, each with its new value
  logic     mcause_rup, mepc_rup, mbadaddr_rup, mstatus_rup, mip_rup;
  mcause_t  mcause_next;
  word_t    mepc_next, mbadaddr_next;
  mstatus_t mstatus_next;
  mirq_t    mip_next;

  modport csr (
    output mtvec, mepc, mstatus, mie, mip,
    input  mcause_rup, mcause_next, mepc_rup, mepc_next,
    input  mbadaddr_rup, mbadaddr_next, mstatus_rup, mstatus_next,
    input  mip_rup, mip_next
  );

  modport prv (
    input  mtvec, mepc, mstatus, mie, mip,
    output mcause_rup, mcause_next, mepc_rup, mepc_next,
    output mbadaddr_rup, mbadaddr_next, mstatus_rup, mstatus_next,
    output mip_rup, mip_next
  );

endinterface

//--- priv/csr_rfile.sv
/*
 * Machine-mode CSR storage with single-cycle read and swap/set/clear update.
 * Pipeline writes land at the next edge and beat trap updates to the same register.
 */
module csr_rfile import machine_mode_pkg::*; #(
  parameter word_t MTVEC_ADDR = 32'h0000_0100,
  parameter word_t HART_ID    = 32'h0000_0000
) (
  input  logic        CLK,
  input  logic        nRST,
  prv_pipeline_if.csr prv_pipe_if,
  csr_prv_if.csr      csr_pr_if,
  input  logic        fromhost_we,
  input  word_t       fromhost_data,
  output word_t       tohost
);

  // Stored state
  logic    ie, ie1;
  logic    mie_msie, mie_mtie;
  logic    mip_msip, mip_mtip;
  word_t   mscratch, mepc, mbadaddr;
  word_t   mtohost, mfromhost;
  mcause_t mcause;

  // Assembled views of the sparse registers
  mstatus_t mstatus;
  mirq_t    mie, mip;

  // Access decode
  word_t     rdata;
  logic      valid_addr;
  logic      csr_op;
  csr_word_u rup;
  logic      wr_mstatus, wr_mie, wr_mscratch, wr_mepc, wr_mtohost;

  always_comb begin
    mstatus      = '0;
    mstatus.ie   = ie;
    mstatus.prv  = PRV_M;
    mstatus.ie1  = ie1;
    mstatus.prv1 = PRV_M;
  end

  always_comb begin
    mie      = '0;
    mie.msie = mie_msie;
    mie.mtie = mie_mtie;
    mip      = '0;
    mip.msie = mip_msip;
    mip.mtie = mip_mtip;
  end

  // Address decode for read data
  always_comb begin
    valid_addr = 1'b1;
    rdata      = '0;
    case (prv_pipe_if.addr)
      MCPUID_ADDR:    rdata = MCPUID_VALUE;
      MIMPID_ADDR:    rdata = '0;
      MHARTID_ADDR:   rdata = HART_ID;
      MSTATUS_ADDR:   rdata = mstatus;
      MTVEC_ADDR_CSR: rdata = MTVEC_ADDR;
      // No delegation in machine-only core
      MTDELEG_ADDR:   rdata = '0;
      MIE_ADDR:       rdata = mie;
      MSCRATCH_ADDR:  rdata = mscratch;
      MEPC_ADDR:      rdata = mepc;
      MCAUSE_ADDR:    rdata = mcause;
      MBADADDR_ADDR:  rdata = mbadaddr;
      MIP_ADDR:       rdata = mip;
      MTOHOST_ADDR:   rdata = mtohost;
      MFROMHOST_ADDR: rdata = mfromhost;
      // Protection, timers and counters read as zero
      12'h380, 12'h381, 12'h382, 12'h383, 12'h384, 12'h385,
      12'hB01, 12'hB81, 12'h321, 12'h701, 12'h741: rdata = '0;
      default: valid_addr = 1'b0;
    endcase
  end

  assign prv_pipe_if.rdata       = rdata;
  assign prv_pipe_if.invalid_csr = ~valid_addr;

  // Swap wins, then clear, else set
  assign csr_op = prv_pipe_if.swap | prv_pipe_if.set | prv_pipe_if.clr;

  always_comb begin
    if (prv_pipe_if.swap) begin
      rup.raw = prv_pipe_if.wdata;
    end else if (prv_pipe_if.clr) begin
      rup.raw = rdata & ~prv_pipe_if.wdata;
    end else begin
      rup.raw = rdata | prv_pipe_if.wdata;
    end
  end

  // Write strobes for the writable registers
  assign wr_mstatus  = csr_op && (prv_pipe_if.addr == MSTATUS_ADDR);
  assign wr_mie      = csr_op && (prv_pipe_if.addr == MIE_ADDR);
  assign wr_mscratch = csr_op && (prv_pipe_if.addr == MSCRATCH_ADDR);
  assign wr_mepc     = csr_op && (prv_pipe_if.addr == MEPC_ADDR);
  assign wr_mtohost  = csr_op && (prv_pipe_if.addr == MTOHOST_ADDR);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ie        <= 1'b1;
      ie1       <= 1'b0;
      mie_msie  <= 1'b0;
      mie_mtie  <= 1'b0;
      mip_msip  <= 1'b0;
      mip_mtip  <= 1'b0;
      mscratch  <= '0;
      mepc      <= '0;
      mcause    <= '0;
      mbadaddr  <= '0;
      mtohost   <= '0;
      mfromhost <= '0;
    end else begin
      // Pipeline write to mstatus beats a trap or mret update
      if (wr_mstatus) begin
        ie  <= rup.mstatus.ie;
        ie1 <= rup.mstatus.ie1;
      end else if (csr_pr_if.mstatus_rup) begin
        ie  <= csr_pr_if.mstatus_next.ie;
        ie1 <= csr_pr_if.mstatus_next.ie1;
      end
      if (wr_mie) begin
        mie_msie <= rup.mirq.msie;
        mie_mtie <= rup.mirq.mtie;
      end
      // Pending bits come only from the synchronizers
      if (csr_pr_if.mip_rup) begin
        mip_msip <= csr_pr_if.mip_next.msie;
        mip_mtip <= csr_pr_if.mip_next.mtie;
      end
      if (wr_mscratch) begin
        mscratch <= rup.raw;
      end
      if (wr_mepc) begin
        mepc <= rup.raw;
      end else if (csr_pr_if.mepc_rup) begin
        mepc <= csr_pr_if.mepc_next;
      end
      if (csr_pr_if.mcause_rup) begin
        mcause <= csr_pr_if.mcause_next;
      end
      if (csr_pr_if.mbadaddr_rup) begin
        mbadaddr <= csr_pr_if.mbadaddr_next;
      end
      if (wr_mtohost) begin
        mtohost <= rup.raw;
      end
      // Host side of the mailbox
      if (fromhost_we) begin
        mfromhost <= fromhost_data;
      end
    end
  end

  // State seen by the trap controller
  assign csr_pr_if.mtvec   = MTVEC_ADDR;
  assign csr_pr_if.mepc    = mepc;
  assign csr_pr_if.mstatus = mstatus;
  assign csr_pr_if.mie     = mie;
  assign csr_pr_if.mip     = mip;

  assign tohost = mtohost;

endmodule

//--- priv/prv_control.sv
/*
 * Trap controller that prioritises exceptions and interrupts, encodes the cause
 * and drives the redirect PC along with the trap-time CSR updates.
 */
module prv_control import machine_mode_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  prv_pipeline_if.prv prv_pipe_if,
  csr_prv_if.prv      csr_pr_if,
  input  logic        ext_soft_int,
  input  logic        ext_timer_int
);

  // Two-flop synchronizers
  logic soft_meta, soft_sync;
  logic timer_meta, timer_sync;

  // Trap selection
  logic     csr_op;
  logic     illegal;
  logic     ex_valid;
  ex_code_t ex_code;
  logic     pend_soft, pend_timer;
  logic     irq_valid;
  logic     trap;
  logic     badaddr_cause;
  mcause_t  cause;
  mstatus_t status_next;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      soft_meta  <= 1'b0;
      soft_sync  <= 1'b0;
      timer_meta <= 1'b0;
      timer_sync <= 1'b0;
    end else begin
      soft_meta  <= ext_soft_int;
      soft_sync  <= soft_meta;
      timer_meta <= ext_timer_int;
      timer_sync <= timer_meta;
    end
  end

  // mip follows the synchronized lines every cycle
  always_comb begin
    csr_pr_if.mip_next      = '0;
    csr_pr_if.mip_next.msie = soft_sync;
    csr_pr_if.mip_next.mtie = timer_sync;
  end
  assign csr_pr_if.mip_rup = 1'b1;

  // Unmapped CSR access is an illegal instruction
  assign csr_op  = prv_pipe_if.swap | prv_pipe_if.set | prv_pipe_if.clr;
  assign illegal = prv_pipe_if.illegal_insn | (csr_op & prv_pipe_if.invalid_csr);

  // Lowest cause code wins
  always_comb begin
    ex_valid = 1'b1;
    ex_code  = EX_MAL_FETCH;
    if (prv_pipe_if.mal_insn) begin
      ex_code = EX_MAL_FETCH;
    end else if (prv_pipe_if.fault_insn) begin
      ex_code = EX_FAULT_FETCH;
    end else if (illegal) begin
      ex_code = EX_ILLEGAL_INSN;
    end else if (prv_pipe_if.ebreak) begin
      ex_code = EX_BREAKPOINT;
    end else if (prv_pipe_if.mal_l) begin
      ex_code = EX_MAL_LOAD;
    end else if (prv_pipe_if.fault_l) begin
      ex_code = EX_FAULT_LOAD;
    end else if (prv_pipe_if.mal_s) begin
      ex_code = EX_MAL_STORE;
    end else if (prv_pipe_if.fault_s) begin
      ex_code = EX_FAULT_STORE;
    end else if (prv_pipe_if.ecall) begin
      ex_code = EX_ECALL_M;
    end else begin
      ex_valid = 1'b0;
    end
  end

  // Interrupt qualified by global and per-source enables
  assign pend_soft  = csr_pr_if.mstatus.ie & csr_pr_if.mip.msie & csr_pr_if.mie.msie;
  assign pend_timer = csr_pr_if.mstatus.ie & csr_pr_if.mip.mtie & csr_pr_if.mie.mtie;
  assign irq_valid  = pend_soft | pend_timer;

  assign trap = ex_valid | irq_valid;

  // Exceptions beat interrupts; software beats timer
  always_comb begin
    cause.interrupt = ~ex_valid;
    if (ex_valid) begin
      cause.code = ex_code;
    end else if (pend_soft) begin
      cause.code = IRQ_SOFT;
    end else begin
      cause.code = IRQ_TIMER;
    end
  end

  // Misaligned and fault causes carry an address
  assign badaddr_cause = (ex_code != EX_ILLEGAL_INSN) && (ex_code != EX_BREAKPOINT) &&
                         (ex_code != EX_ECALL_M);

  // Push the enable stack on trap, pop on mret
  always_comb begin
    status_next      = csr_pr_if.mstatus;
    status_next.prv  = PRV_M;
    status_next.prv1 = PRV_M;
    if (trap) begin
      status_next.ie1 = csr_pr_if.mstatus.ie;
      status_next.ie  = 1'b0;
    end else begin
      status_next.ie  = csr_pr_if.mstatus.ie1;
      status_next.ie1 = 1'b1;
    end
  end

  assign csr_pr_if.mcause_rup    = trap;
  assign csr_pr_if.mcause_next   = cause;
  assign csr_pr_if.mepc_rup      = trap;
  assign csr_pr_if.mepc_next     = prv_pipe_if.ex_pc;
  assign csr_pr_if.mbadaddr_rup  = ex_valid & badaddr_cause;
  assign csr_pr_if.mbadaddr_next = prv_pipe_if.ex_badaddr;
  assign csr_pr_if.mstatus_rup   = trap | prv_pipe_if.mret;
  assign csr_pr_if.mstatus_next  = status_next;

  // Redirect to handler or back to mepc
  assign prv_pipe_if.insert_pc = trap | prv_pipe_if.mret;
  assign prv_pipe_if.priv_pc   = trap ? csr_pr_if.mtvec : csr_pr_if.mepc;

endmodule

//--- rtl/priv_block.sv
/*
 * Top of the machine-mode privilege unit.
 * Plain pipeline and host ports mapped onto the CSR file and trap controller.
 */
module priv_block import machine_mode_pkg::*; #(
  parameter word_t MTVEC_ADDR = 32'h0000_0100,
  parameter word_t HART_ID    = 32'h0000_0000
) (
  input  logic      CLK,
  input  logic      nRST,
  // CSR access
  input  csr_addr_t csr_addr,
  input  logic      csr_swap,
  input  logic      csr_set,
  input  logic      csr_clr,
  input  word_t     csr_wdata,
  // Trap sources
  input  word_t     ex_pc,
  input  word_t     ex_badaddr,
  input  logic      mal_insn,
  input  logic      fault_insn,
  input  logic      illegal_insn,
  input  logic      ebreak,
  input  logic      ecall,
  input  logic      mal_l,
  input  logic      fault_l,
  input  logic      mal_s,
  input  logic      fault_s,
  input  logic      mret,
  input  logic      ext_soft_int,
  input  logic      ext_timer_int,
  // Host mailbox
  input  logic      fromhost_we,
  input  word_t     fromhost_data,
  output word_t     csr_rdata,
  output logic      invalid_csr,
  output logic      insert_pc,
  output word_t     priv_pc,
  output word_t     tohost
);

  prv_pipeline_if pipe_if ();
  csr_prv_if      cp_if ();

  assign pipe_if.addr         = csr_addr;
  assign pipe_if.swap         = csr_swap;
  assign pipe_if.set          = csr_set;
  assign pipe_if.clr          = csr_clr;
  assign pipe_if.wdata        = csr_wdata;
  assign pipe_if.ex_pc        = ex_pc;
  assign pipe_if.ex_badaddr   = ex_badaddr;
  assign pipe_if.mal_insn     = mal_insn;
  assign pipe_if.fault_insn   = fault_insn;
  assign pipe_if.illegal_insn = illegal_insn;
  assign pipe_if.ebreak       = ebreak;
  assign pipe_if.ecall        = ecall;
  assign pipe_if.mal_l        = mal_l;
  assign pipe_if.fault_l      = fault_l;
  assign pipe_if.mal_s        = mal_s;
  assign pipe_if.fault_s      = fault_s;
  assign pipe_if.mret         = mret;

  assign csr_rdata   = pipe_if.rdata;
  assign invalid_csr = pipe_if.invalid_csr;
  assign insert_pc   = pipe_if.insert_pc;
  assign priv_pc     = pipe_if.priv_pc;

  csr_rfile #(
    .MTVEC_ADDR(MTVEC_ADDR),
    .HART_ID   (HART_ID)
  ) u_csr_rfile (
    .CLK          (CLK),
    .nRST         (nRST),
    .prv_pipe_if  (pipe_if),
    .csr_pr_if    (cp_if),
    .fromhost_we  (fromhost_we),
    .fromhost_data(fromhost_data),
    .tohost       (tohost)
  );

  prv_control u_prv_control (
    .CLK          (CLK),
    .nRST         (nRST),
    .prv_pipe_if  (pipe_if),
    .csr_pr_if    (cp_if),
    .ext_soft_int (ext_soft_int),
    .ext_timer_int(ext_timer_int)
  );

endmodule

//--- bench/tb_priv_block.sv
/*
 * Directed testbench for the machine-mode privilege unit.
 * Runs CSR access, exceptions, priority, mret and interrupts against priv_block.
 */
module tb_priv_block;

  // DUT defaults and architectural constants
  localparam logic [31:0] MTVEC_EXP  = 32'h0000_0100;
  localparam logic [31:0] HART_EXP   = 32'h0000_0000;
  localparam logic [31:0] MCPUID_EXP = 32'h4000_0100;
  localparam int          WATCHDOG_T = 40000;

  logic        CLK;
  logic        nRST;
  logic [11:0] csr_addr;
  logic        csr_swap, csr_set, csr_clr;
  logic [31:0] csr_wdata, ex_pc, ex_badaddr;
  logic        mal_insn, fault_insn, illegal_insn, ebreak, ecall;
  logic        mal_l, fault_l, mal_s, fault_s, mret;
  logic        ext_soft_int, ext_timer_int, fromhost_we;
  logic [31:0] fromhost_data;
  logic [31:0] csr_rdata, priv_pc, tohost;
  logic        invalid_csr, insert_pc;

  integer seed;
  integer err_count;
  integer check_count;
  logic   read_invalid;

  priv_block UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // About 2000 cycles against a few hundred for the full run
  initial begin
    #WATCHDOG_T;
    $display("Watchdog expired before all tests completed");
    $display("TEST FAIL");
    $finish;
  end

  // Inputs change 2 units after the edge
  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // prv and prv1 always read as machine mode
  function automatic logic [31:0] mstatus_word(input logic ie, input logic ie1);
    mstatus_word = 32'h0000_0036 | {28'd0, ie1, 3'd0} | {31'd0, ie};
  endfunction

  task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
    csr_addr = addr;
    #1;
    data         = csr_rdata;
    read_invalid = invalid_csr;
    next_cycle();
  endtask

  // op 0 swap, 1 set, 2 clear
  task automatic csr_access(input int op, input logic [11:0] addr, input logic [31:0] data);
    csr_addr  = addr;
    csr_wdata = data;
    csr_swap  = (op == 0);
    csr_set   = (op == 1);
    csr_clr   = (op == 2);
    next_cycle();
    csr_swap = 1'b0;
    csr_set  = 1'b0;
    csr_clr  = 1'b0;
  endtask

  // Bit order follows the cause code order with ecall last
  task automatic drive_sources(input logic [8:0] mask);
    mal_insn     = mask[0];
    fault_insn   = mask[1];
    illegal_insn = mask[2];
    ebreak       = mask[3];
    mal_l        = mask[4];
    fault_l      = mask[5];
    mal_s        = mask[6];
    fault_s      = mask[7];
    ecall        = mask[8];
  endtask

  task automatic info_and_zero_regs();
    logic [11:0] zero_addrs [12];
    logic [31:0] rd;
    zero_addrs = '{12'h302, 12'h380, 12'h381, 12'h382, 12'h383, 12'h384,
                   12'h385, 12'hB01, 12'hB81, 12'h321, 12'h701, 12'h741};
    csr_read(12'hF00, rd);
    compare("mcpuid", MCPUID_EXP, rd);
    csr_read(12'hF10, rd);
    compare("mhartid", HART_EXP, rd);
    csr_read(12'h301, rd);
    compare("mtvec", MTVEC_EXP, rd);
    foreach (zero_addrs[i]) begin
      csr_read(zero_addrs[i], rd);
      compare($sformatf("zero-read %h data", zero_addrs[i]), 32'd0, rd);
      compare($sformatf("zero-read %h invalid", zero_addrs[i]), 32'd0, {31'd0, read_invalid});
    end
    csr_read(12'h123, rd);
    compare("unmapped read data", 32'd0, rd);
    compare("unmapped read invalid", 32'd1, {31'd0, read_invalid});
    // Read-only register ignores a swap
    csr_access(0, 12'hF00, $random(seed));
    csr_read(12'hF00, rd);
    compare("mcpuid after write", MCPUID_EXP, rd);
  endtask

  task automatic rw_register(input string name, input logic [11:0] addr,
                             input logic [31:0] mask, input logic [31:0] fixed);
    logic [31:0] val, rd, w;
    csr_read(addr, val);
    for (int k = 0; k < 6; k++) begin
      w = $random(seed);
      case (k % 3)
        0:       val = w;
        1:       val = val | w;
        default: val = val & ~w;
      endcase
      val = (val & mask) | fixed;
      csr_access(k % 3, addr, w);
      csr_read(addr, rd);
      compare($sformatf("%s op %0d", name, k), val, rd);
    end
  endtask

  task automatic read_update_write();
    logic [31:0] w, rd;
    rw_register("mscratch", 12'h340, 32'hFFFF_FFFF, 32'd0);
    rw_register("mepc", 12'h341, 32'hFFFF_FFFF, 32'd0);
    rw_register("mie", 12'h304, 32'h0000_0088, 32'd0);
    rw_register("mstatus", 12'h300, 32'h0000_0009, 32'h0000_0036);
    csr_access(0, 12'h304, 32'd0);
    csr_access(0, 12'h300, 32'd1);
    // Host mailbox in both directions
    w = $random(seed);
    csr_access(0, 12'h780, w);
    compare("tohost port", w, tohost);
    w = $random(seed);
    fromhost_data = w;
    fromhost_we   = 1'b1;
    next_cycle();
    fromhost_we = 1'b0;
    csr_read(12'h781, rd);
    compare("mfromhost", w, rd);
  endtask

  task automatic raise_exception(input string name, input logic [8:0] mask,
                                 input logic prior_ie);
    logic [31:0] pc, bad, old_bad, rd, exp_code;
    int lowest;
    csr_access(0, 12'h300, {31'd0, prior_ie});
    csr_read(12'h343, old_bad);
    lowest = 0;
    for (int i = 8; i >= 0; i--) begin
      if (mask[i]) begin
        lowest = i;
      end
    end
    exp_code   = (lowest == 8) ? 32'd11 : lowest;
    pc         = $random(seed) & 32'hFFFF_FFFC;
    bad        = $random(seed);
    ex_pc      = pc;
    ex_badaddr = bad;
    drive_sources(mask);
    #1;
    compare({name, " insert_pc"}, 32'd1, {31'd0, insert_pc});
    compare({name, " priv_pc"}, MTVEC_EXP, priv_pc);
    next_cycle();
    drive_sources(9'd0);
    csr_read(12'h342, rd);
    compare({name, " mcause"}, exp_code, rd);
    csr_read(12'h341, rd);
    compare({name, " mepc"}, pc, rd);
    // Illegal, breakpoint and ecall leave mbadaddr alone
    csr_read(12'h343, rd);
    compare({name, " mbadaddr"},
            (lowest == 2 || lowest >= 8 || lowest == 3) ? old_bad : bad, rd);
    csr_read(12'h300, rd);
    compare({name, " mstatus"}, mstatus_word(1'b0, prior_ie), rd);
  endtask

  task automatic exception_sources();
    string names [9];
    logic [8:0] m;
    names = '{"mal_insn", "fault_insn", "illegal_insn", "ebreak", "mal_l",
              "fault_l", "mal_s", "fault_s", "ecall"};
    for (int i = 0; i < 9; i++) begin
      m = 9'd1 << i;
      raise_exception(names[i], m, i[0]);
    end
  endtask

  task automatic priority_order();
    raise_exception("prio fetch fault", 9'b1_0000_0110, 1'b1);
    raise_exception("prio illegal", 9'b1_1000_0100, 1'b1);
    raise_exception("prio ebreak", 9'b0_1111_1000, 1'b0);
    raise_exception("prio load", 9'b1_1111_0000, 1'b1);
    raise_exception("prio store", 9'b1_1100_0000, 1'b1);
    raise_exception("prio all", 9'b1_1111_1111, 1'b1);
  endtask

  task automatic unmapped_csr_op();
    logic [31:0] pc, rd;
    csr_access(0, 12'h300, 32'd1);
    pc        = $random(seed) & 32'hFFFF_FFFC;
    ex_pc     = pc;
    csr_addr  = 12'h123;
    csr_wdata = $random(seed);
    csr_set   = 1'b1;
    #1;
    compare("unmapped op invalid_csr", 32'd1, {31'd0, invalid_csr});
    compare("unmapped op insert_pc", 32'd1, {31'd0, insert_pc});
    compare("unmapped op priv_pc", MTVEC_EXP, priv_pc);
    next_cycle();
    csr_set = 1'b0;
    csr_read(12'h342, rd);
    compare("unmapped op mcause", 32'd2, rd);
    csr_read(12'h341, rd);
    compare("unmapped op mepc", pc, rd);
  endtask

  task automatic mret_return();
    logic [31:0] target, rd;
    logic saved;
    target = $random(seed) & 32'hFFFF_FFFC;
    csr_access(0, 12'h341, target);
    for (int k = 0; k < 2; k++) begin
      saved = k[0];
      csr_access(0, 12'h300, {28'd0, saved, 3'd0});
      mret = 1'b1;
      #1;
      compare("mret insert_pc", 32'd1, {31'd0, insert_pc});
      compare("mret priv_pc", target, priv_pc);
      next_cycle();
      mret = 1'b0;
      csr_read(12'h300, rd);
      compare("mret mstatus", mstatus_word(saved, 1'b1), rd);
    end
  endtask

  task automatic interrupt_case(input string name, input logic timer, input logic en,
                                input logic ie_on);
    logic [31:0] bit_mask, rd;
    logic take;
    bit_mask = timer ? 32'h0000_0080 : 32'h0000_0008;
    take     = en & ie_on;
    csr_access(0, 12'h304, en ? bit_mask : 32'd0);
    csr_access(0, 12'h300, {31'd0, ie_on});
    ext_soft_int  = ~timer;
    ext_timer_int = timer;
    if (take) begin
      // Two synchronizer flops, then the mip register
      for (int e = 0; e <= 3; e++) begin
        if (e > 0) begin
          next_cycle();
        end
        #1;
        compare($sformatf("%s insert_pc edge %0d", name, e),
                {31'd0, e == 3}, {31'd0, insert_pc});
      end
      compare({name, " priv_pc"}, MTVEC_EXP, priv_pc);
      next_cycle();
      csr_read(12'h342, rd);
      compare({name, " mcause"}, timer ? 32'h8000_0007 : 32'h8000_0003, rd);
    end else begin
      for (int e = 0; e < 10; e++) begin
        #1;
        check_count++;
        if (insert_pc) begin
          err_count++;
          $display("%s: insert_pc went high although the interrupt is masked", name);
        end
        next_cycle();
      end
      csr_read(12'h344, rd);
      compare({name, " mip"}, bit_mask, rd);
    end
    ext_soft_int  = 1'b0;
    ext_timer_int = 1'b0;
    // Drain synchronizers and mip
    repeat (4) next_cycle();
    csr_access(0, 12'h304, 32'd0);
    csr_access(0, 12'h300, 32'd1);
  endtask

  initial begin
    seed          = 32'h617c14a6;
    err_count     = 0;
    check_count   = 0;
    read_invalid  = 1'b0;
    nRST          = 1'b0;
    csr_addr      = 12'd0;
    csr_swap      = 1'b0;
    csr_set       = 1'b0;
    csr_clr       = 1'b0;
    csr_wdata     = 32'd0;
    ex_pc         = 32'd0;
    ex_badaddr    = 32'd0;
    mret          = 1'b0;
    ext_soft_int  = 1'b0;
    ext_timer_int = 1'b0;
    fromhost_we   = 1'b0;
    fromhost_data = 32'd0;
    drive_sources(9'd0);
    repeat (16) @(posedge CLK);
    #2;
    nRST = 1'b1;
    next_cycle();
    info_and_zero_regs();
    read_update_write();
    exception_sources();
    priority_order();
    unmapped_csr_op();
    mret_return();
    interrupt_case("soft irq", 1'b0, 1'b1, 1'b1);
    interrupt_case("timer irq", 1'b1, 1'b1, 1'b1);
    interrupt_case("soft masked by mie", 1'b0, 1'b0, 1'b1);
    interrupt_case("timer masked by ie", 1'b1, 1'b1, 1'b0);
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
common/machine_mode_pkg.sv
common/prv_pipeline_if.sv
common/csr_prv_if.sv
priv/csr_rfile.sv
priv/prv_control.sv
rtl/priv_block.sv
bench/tb_priv_block.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the privilege unit testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module tb_priv_block \
  && out="$(./obj_dir/Vtb_priv_block)" \
  || { echo "$out"; echo "Build or simulation failed"; exit 1; }
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || exit 1
